//--- Makefile
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP)
RUNFLAGS  := +verilator+error+limit+1000
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	out=$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS)); echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/core_checker.sv
`default_nettype none

module core_checker (
   input wire        clk,
   input wire        i_rst_n,
   input wire [31:0] o_ibus_adr,
   input wire        o_ibus_cyc,
   input wire        i_ibus_ack,
   input wire [31:0] o_dbus_adr,
   input wire [31:0] o_dbus_dat,
   input wire        o_dbus_cyc,
   input wire        i_dbus_ack
);

   int unsigned fail_cnt = 0;

   // Request held until ack
   ibus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc && $stable(o_ibus_adr))
      else begin
         $error("ibus request dropped or address changed before ack");
         fail_cnt++;
      end

   dbus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_dbus_cyc && !i_dbus_ack |=>
         o_dbus_cyc && $stable(o_dbus_adr) && $stable(o_dbus_dat))
      else begin
         $error("dbus request dropped or address/data changed before ack");
         fail_cnt++;
      end

   cyc_in_reset: assert property (@(posedge clk)
      !i_rst_n |=> !o_ibus_cyc && !o_dbus_cyc)
      else begin
         $error("bus cycle active during reset");
         fail_cnt++;
      end

   one_bus_only: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_ibus_cyc && o_dbus_cyc))
      else begin
         $error("ibus and dbus cycles active together");
         fail_cnt++;
      end

   ibus_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_ibus_cyc |-> o_ibus_adr[1:0] == 2'b00)
      else begin
         $error("ibus address not word aligned");
         fail_cnt++;
      end

endmodule

bind bit_core_top core_checker chk (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .o_ibus_adr (o_ibus_adr),
   .o_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .o_dbus_adr (o_dbus_adr),
   .o_dbus_dat (o_dbus_dat),
   .o_dbus_cyc (o_dbus_cyc),
   .i_dbus_ack (i_dbus_ack)
);

`default_nettype wire

//--- dv/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
   output logic clk
);

   // Period of 4 time units
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`default_nettype none

module tb_top;

   localparam int RESET_CYCLES = 10;
   localparam int PROG_WORDS   = 64;
   localparam int MAX_FETCH    = 128;
   localparam int MAX_STORE    = 32;

   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_STORE  = 7'b0100011;

   wire        clk;
   logic       i_rst_n    = 1'b0;
   logic [31:0] i_ibus_rdt = '0;
   logic       i_ibus_ack = 1'b0;
   logic       i_dbus_ack = 1'b0;
   wire [31:0] o_ibus_adr;
   wire        o_ibus_cyc;
   wire [31:0] o_dbus_adr;
   wire [31:0] o_dbus_dat;
   wire        o_dbus_cyc;

   logic [31:0] prog [PROG_WORDS];
   int          plen;
   logic [31:0] exp_fetch [MAX_FETCH];
   logic [31:0] exp_adr [MAX_STORE];
   logic [31:0] exp_dat [MAX_STORE];
   int          n_fetch;
   int          n_store;
   int          fetch_idx;
   int          store_idx;
   int          i_wait;
   int          d_wait;
   int unsigned done_cnt   = 0;
   int unsigned bus_errs   = 0;
   int unsigned end_errs   = 0;
   int unsigned cycles     = 0;
   int unsigned limit      = 0;
   logic [31:0] rng        = 32'd65;
   logic        random_acks = 1'b0;
   int          n_pass     = 0;
   int          n_fail     = 0;

   tb_clkgen clkgen (.clk(clk));

   bit_core_top dut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd);
      return {imm, rs1, 3'b000, rd, OP_IMM};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, OP_LUI};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   function automatic string test_name(input int id);
      case (id)
         1:       return "arithmetic";
         2:       return "lui constant";
         3:       return "branches";
         4:       return "jal link";
         default: return "x0 writes";
      endcase
   endfunction

   task automatic add_ins(input logic [31:0] w);
      prog[plen] = w;
      plen++;
   endtask

   task automatic build_program(input int id);
      // Unknown opcode that also carries its word index
      for (int i = 0; i < PROG_WORDS; i++)
         prog[i] = {25'(i), 7'h7F};
      plen = 0;
      case (id)
         1: begin
            add_ins(enc_i(12'd100, 5'd0, 5'd1));
            add_ins(enc_i(12'hFF9, 5'd0, 5'd2));
            add_ins(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
            add_ins(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
            add_ins(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
            add_ins(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
            add_ins(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
            add_ins(enc_i(12'hF38, 5'd1, 5'd8));
            for (int r = 3; r <= 8; r++)
               add_ins(enc_s(12'(256 + 4 * r), 5'(r), 5'd0));
         end
         2: begin
            add_ins(enc_u(20'h12345, 5'd1));
            add_ins(enc_i(12'h678, 5'd1, 5'd1));
            add_ins(enc_u(20'hDEADC, 5'd2));
            add_ins(enc_i(12'hEEF, 5'd2, 5'd2));
            add_ins(enc_s(12'h100, 5'd1, 5'd0));
            add_ins(enc_s(12'h104, 5'd2, 5'd0));
         end
         3: begin
            add_ins(enc_i(12'd5, 5'd0, 5'd1));
            add_ins(enc_i(12'd5, 5'd0, 5'd2));
            add_ins(enc_i(12'd9, 5'd0, 5'd3));
            add_ins(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
            add_ins(enc_s(12'h100, 5'd3, 5'd0));
            add_ins(enc_s(12'h104, 5'd1, 5'd0));
            add_ins(enc_b(13'd8, 5'd3, 5'd1, 3'b000));
            add_ins(enc_s(12'h108, 5'd3, 5'd0));
            add_ins(enc_b(13'd8, 5'd3, 5'd1, 3'b001));
            add_ins(enc_s(12'h10C, 5'd1, 5'd0));
            add_ins(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
            add_ins(enc_s(12'h110, 5'd2, 5'd0));
         end
         4: begin
            add_ins(enc_i(12'd1, 5'd0, 5'd1));
            add_ins(enc_j(21'd12, 5'd5));
            add_ins(enc_s(12'h100, 5'd1, 5'd0));
            add_ins(enc_i(12'd2, 5'd0, 5'd1));
            add_ins(enc_s(12'h104, 5'd5, 5'd0));
            add_ins(enc_s(12'h108, 5'd1, 5'd0));
         end
         default: begin
            add_ins(enc_i(12'd3, 5'd0, 5'd1));
            add_ins(enc_i(12'd55, 5'd0, 5'd0));
            add_ins(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
            add_ins(enc_u(20'hFFFFF, 5'd0));
            add_ins(enc_j(21'd4, 5'd0));
            // Outside the subset with rd field x31
            add_ins(32'hFFFF_FFFF);
            add_ins(enc_s(12'h100, 5'd0, 5'd0));
            add_ins(enc_s(12'h104, 5'd31, 5'd0));
            add_ins(enc_s(12'h108, 5'd1, 5'd0));
         end
      endcase
      // Jump to self ends the program
      add_ins(enc_j(21'd0, 5'd0));
   endtask

   // Reference execution of the program by the RV32I rules
   task automatic model_run();
      logic [31:0] r [32];
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] nxt;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_b;
      logic [31:0] imm_j;
      logic        wr;
      logic        halted;
      for (int i = 0; i < 32; i++)
         r[i] = '0;
      pc = '0;
      n_fetch = 0;
      n_store = 0;
      halted = 1'b0;
      while (!halted && n_fetch < MAX_FETCH) begin
         ins = prog[pc[7:2]];
         exp_fetch[n_fetch] = pc;
         n_fetch++;
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         a = r[ins[19:15]];
         b = (ins[6:0] == OP_IMM) ? imm_i : r[ins[24:20]];
         nxt = pc + 32'd4;
         wr = 1'b0;
         res = '0;
         case (ins[6:0])
            OP_REG, OP_IMM: begin
               wr = 1'b1;
               case (ins[14:12])
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  default: res = (ins[6:0] == OP_REG && ins[30]) ? a - b : a + b;
               endcase
            end
            OP_LUI: begin
               wr = 1'b1;
               res = {ins[31:12], 12'h000};
            end
            OP_BRANCH: begin
               // BNE has funct3 bit 0 set
               if ((a == b) != ins[12])
                  nxt = pc + imm_b;
            end
            OP_JAL: begin
               wr = 1'b1;
               res = pc + 32'd4;
               halted = (imm_j == '0);
               nxt = pc + imm_j;
            end
            OP_STORE: begin
               exp_adr[n_store] = (a + imm_s) & 32'hFFFF_FFFC;
               exp_dat[n_store] = r[ins[24:20]];
               n_store++;
            end
            default: wr = 1'b0;
         endcase
         if (wr && ins[11:7] != 5'd0)
            r[ins[11:7]] = res;
         pc = nxt;
      end
   endtask

   task automatic check_fetch();
      assert (o_ibus_adr == exp_fetch[fetch_idx]) else begin
         $display("FAILED o_ibus_adr: got %h, expected %h",
                  o_ibus_adr, exp_fetch[fetch_idx]);
         bus_errs++;
      end
      fetch_idx++;
      if (fetch_idx == n_fetch)
         done_cnt++;
   endtask

   task automatic check_store();
      assert (store_idx < n_store) else begin
         $display("store to %h that the program does not make", o_dbus_adr);
         bus_errs++;
      end
      if (store_idx < n_store) begin
         assert (o_dbus_adr == exp_adr[store_idx]) else begin
            $display("FAILED o_dbus_adr: got %h, expected %h",
                     o_dbus_adr, exp_adr[store_idx]);
            bus_errs++;
         end
         assert (o_dbus_dat == exp_dat[store_idx]) else begin
            $display("FAILED o_dbus_dat: got %h, expected %h",
                     o_dbus_dat, exp_dat[store_idx]);
            bus_errs++;
         end
         store_idx++;
      end
   endtask

   // Bus models with an ack delay of 0 to 7 cycles
   always @(negedge clk) begin
      if (!i_rst_n) begin
         i_ibus_ack = 1'b0;
         i_dbus_ack = 1'b0;
         i_wait = -1;
         d_wait = -1;
         fetch_idx = 0;
         store_idx = 0;
      end else begin
         if (i_ibus_ack) begin
            i_ibus_ack = 1'b0;
         end else if (o_ibus_cyc) begin
            if (i_wait < 0) begin
               rng = xorshift32(rng);
               i_wait = random_acks ? int'(rng[2:0]) : 0;
            end
            if (i_wait == 0) begin
               check_fetch();
               i_ibus_rdt = prog[o_ibus_adr[7:2]];
               i_ibus_ack = 1'b1;
               i_wait = -1;
            end else begin
               i_wait--;
            end
         end
         if (i_dbus_ack) begin
            i_dbus_ack = 1'b0;
         end else if (o_dbus_cyc) begin
            if (d_wait < 0) begin
               rng = xorshift32(rng);
               d_wait = random_acks ? int'(rng[2:0]) : 0;
            end
            if (d_wait == 0) begin
               check_store();
               i_dbus_ack = 1'b1;
               d_wait = -1;
            end else begin
               d_wait--;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout after %0d cycles, program did not reach its end", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic apply_reset();
      @(negedge clk);
      i_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      i_rst_n = 1'b1;
   endtask

   task automatic run_test(input int id, input logic rnd);
      int unsigned errs_at_start;
      int unsigned done_at_start;
      logic        ok;
      build_program(id);
      model_run();
      // 32 run cycles plus up to 8 wait cycles on each bus
      limit += n_fetch * 48 + RESET_CYCLES + 4;
      random_acks = rnd;
      errs_at_start = bus_errs + end_errs + dut.chk.fail_cnt;
      done_at_start = done_cnt;
      apply_reset();
      while (done_cnt == done_at_start)
         @(posedge clk);
      assert (store_idx == n_store) else begin
         $display("only %0d of %0d expected stores completed", store_idx, n_store);
         end_errs++;
      end
      ok = (bus_errs + end_errs + dut.chk.fail_cnt == errs_at_start);
      if (ok)
         n_pass++;
      else
         n_fail++;
      $display("test %0d %s (%s acks): %s", id, test_name(id),
               rnd ? "random" : "zero-delay", ok ? "passed" : "failed");
   endtask

   initial begin
      for (int p = 1; p <= 5; p++)
         run_test(p, 1'b0);
      for (int p = 1; p <= 5; p++)
         run_test(p, 1'b1);
      $display("%0d tests: %0d passed, %0d failed, %0d errors, %0d checker failures",
               n_pass + n_fail, n_pass, n_fail, bus_errs + end_errs, dut.chk.fail_cnt);
      if (n_fail == 0 && bus_errs + end_errs + dut.chk.fail_cnt == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/bit_alu.sv
`default_nettype none

module bit_alu
   import serv_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   bit_ctrl_if.exe       ctrl,
   input  wire           i_run,
   input  wire bit_cnt_t i_cnt,
   input  wire           i_rs1_bit,
   input  wire           i_rs2_bit,
   input  wire           i_imm_bit,
   output logic          o_alu_bit,
   output logic          o_cmp_eq
);

   logic first;
   logic op_b;
   logic sub;
   logic b_in;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic same;
   logic eq_q;

   assign first    = (i_cnt == '0);
   assign op_b     = ctrl.op_b_imm ? i_imm_bit : i_rs2_bit;
   assign sub      = (ctrl.alu_op == ALU_SUB);
   assign b_in     = op_b ^ sub;
   // Carry of one at bit 0 completes the two's complement
   assign carry_in = first ? sub : carry_q;
   assign sum      = i_rs1_bit ^ b_in ^ carry_in;
   assign same     = ~(i_rs1_bit ^ op_b);
   assign o_cmp_eq = same & (first | eq_q);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else if (i_run) begin
         carry_q <= (i_rs1_bit & b_in) | (i_rs1_bit & carry_in) | (b_in & carry_in);
         eq_q    <= o_cmp_eq;
      end
   end

   always_comb begin
      case (ctrl.alu_op)
         ALU_AND: o_alu_bit = i_rs1_bit & op_b;
         ALU_OR:  o_alu_bit = i_rs1_bit | op_b;
         ALU_XOR: o_alu_bit = i_rs1_bit ^ op_b;
         default: o_alu_bit = sum;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/bit_core_top.sv
`default_nettype none

module bit_core_top
   import serv_pkg::*;
(
   input  wire        clk,
   input  wire        i_rst_n,
   input  wire word_t i_ibus_rdt,
   input  wire        i_ibus_ack,
   output wire word_t o_ibus_adr,
   output wire        o_ibus_cyc,
   output wire word_t o_dbus_adr,
   output wire word_t o_dbus_dat,
   output wire        o_dbus_cyc,
   input  wire        i_dbus_ack
);

   wire           run;
   wire           cnt_done;
   wire bit_cnt_t cnt;
   wire           imm_bit;
   wire           rs1_bit;
   wire           rs2_bit;
   wire           alu_bit;
   wire           link_bit;
   wire           take_branch;
   wire           cmp_eq;

   bit_ctrl_if ctrl ();

   bit_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_is_store (ctrl.is_store),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_run      (run),
      .o_cnt      (cnt),
      .o_cnt_done (cnt_done)
   );

   bit_decode decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .i_cnt         (cnt),
      .i_cmp_eq      (cmp_eq),
      .o_imm_bit     (imm_bit),
      .o_take_branch (take_branch),
      .ctrl          (ctrl.dec)
   );

   bit_alu alu (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .ctrl      (ctrl.exe),
      .i_run     (run),
      .i_cnt     (cnt),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .o_alu_bit (alu_bit),
      .o_cmp_eq  (cmp_eq)
   );

   bit_regfile regfile (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .ctrl       (ctrl.exe),
      .i_run      (run),
      .i_cnt      (cnt),
      .i_alu_bit  (alu_bit),
      .i_imm_bit  (imm_bit),
      .i_link_bit (link_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   bit_pc_ctrl pc_ctrl (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .ctrl          (ctrl.pc),
      .i_run         (run),
      .i_cnt         (cnt),
      .i_cnt_done    (cnt_done),
      .i_imm_bit     (imm_bit),
      .i_take_branch (take_branch),
      .o_link_bit    (link_bit),
      .o_ibus_adr    (o_ibus_adr)
   );

   bit_mem_if mem_if (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_run      (run),
      .i_alu_bit  (alu_bit),
      .i_rs2_bit  (rs2_bit),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule

`default_nettype wire

//--- hdl/bit_ctrl_if.sv
`default_nettype none

interface bit_ctrl_if
   import serv_pkg::*;
   ();

   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   logic      rd_en;
   alu_op_e   alu_op;
   logic      op_b_imm;
   rd_src_e   rd_src;
   logic      is_branch;
   logic      is_jal;
   logic      is_store;

   modport dec (
      output rs1_addr, rs2_addr, rd_addr, rd_en, alu_op, op_b_imm, rd_src,
      output is_branch, is_jal, is_store
   );

   modport exe (
      input rs1_addr, rs2_addr, rd_addr, rd_en, alu_op, op_b_imm, rd_src
   );

   modport pc (input is_branch, is_jal);

endinterface

`default_nettype wire

//--- hdl/bit_decode.sv
`default_nettype none

module bit_decode
   import serv_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire word_t    i_ibus_rdt,
   input  wire           i_ibus_ack,
   input  wire bit_cnt_t i_cnt,
   input  wire           i_cmp_eq,
   output logic          o_imm_bit,
   output logic          o_take_branch,
   bit_ctrl_if.dec       ctrl
);

   word_t      ir;
   word_t      imm;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       is_op;
   logic       is_opimm;
   logic       is_lui;

   // Cleared to an unknown opcode so nothing is written before the first fetch
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         ir <= '0;
      else if (i_ibus_ack)
         ir <= i_ibus_rdt;
   end

   assign opcode   = ir[6:0];
   assign funct3   = ir[14:12];
   assign is_op    = (opcode == OPC_OP);
   assign is_opimm = (opcode == OPC_OPIMM);
   assign is_lui   = (opcode == OPC_LUI);

   assign ctrl.is_branch = (opcode == OPC_BRANCH);
   assign ctrl.is_jal    = (opcode == OPC_JAL);
   assign ctrl.is_store  = (opcode == OPC_STORE);
   assign ctrl.rs1_addr  = ir[19:15];
   assign ctrl.rs2_addr  = ir[24:20];
   assign ctrl.rd_addr   = ir[11:7];
   assign ctrl.rd_en     = is_op | is_opimm | is_lui | ctrl.is_jal;
   assign ctrl.op_b_imm  = is_opimm | ctrl.is_store;
   assign ctrl.rd_src    = is_lui ? RD_IMM : (ctrl.is_jal ? RD_LINK : RD_ALU);

   always_comb begin
      case (funct3)
         3'b100:  ctrl.alu_op = ALU_XOR;
         3'b110:  ctrl.alu_op = ALU_OR;
         3'b111:  ctrl.alu_op = ALU_AND;
         default: ctrl.alu_op = (is_op && ir[30]) ? ALU_SUB : ALU_ADD;
      endcase
   end

   always_comb begin
      case (opcode)
         OPC_STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         OPC_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
         OPC_LUI:    imm = {ir[31:12], 12'h000};
         OPC_JAL:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
         default:    imm = {{20{ir[31]}}, ir[31:20]};
      endcase
   end

   assign o_imm_bit = imm[i_cnt];

   // funct3[0] turns BEQ into BNE
   assign o_take_branch = ctrl.is_branch & (i_cmp_eq ^ funct3[0]);

endmodule

`default_nettype wire

//--- hdl/bit_mem_if.sv
`default_nettype none

module bit_mem_if
   import serv_pkg::*;
(
   input  wire   clk,
   input  wire   i_rst_n,
   input  wire   i_run,
   input  wire   i_alu_bit,
   input  wire   i_rs2_bit,
   output word_t o_dbus_adr,
   output word_t o_dbus_dat
);

   // Only the upper 30 address bits are kept after 32 shifts
   logic [29:0] adr_q;
   word_t       dat_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         adr_q <= '0;
         dat_q <= '0;
      end else if (i_run) begin
         adr_q <= {i_alu_bit, adr_q[29:1]};
         dat_q <= {i_rs2_bit, dat_q[31:1]};
      end
   end

   assign o_dbus_adr = {adr_q, 2'b00};
   assign o_dbus_dat = dat_q;

endmodule

`default_nettype wire

//--- hdl/bit_pc_ctrl.sv
`default_nettype none

module bit_pc_ctrl
   import serv_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   bit_ctrl_if.pc        ctrl,
   input  wire           i_run,
   input  wire bit_cnt_t i_cnt,
   input  wire           i_cnt_done,
   input  wire           i_imm_bit,
   input  wire           i_take_branch,
   output logic          o_link_bit,
   output word_t         o_ibus_adr
);

   word_t       pc;
   logic [30:0] pc4_q;
   logic [30:0] tgt_q;
   logic        first;
   logic        pc_bit;
   logic        four_bit;
   logic        c4_in;
   logic        c4_q;
   logic        s4;
   logic        ct_in;
   logic        ct_q;
   logic        st;
   logic        jump;

   assign first    = (i_cnt == '0);
   assign pc_bit   = pc[i_cnt];
   assign four_bit = (i_cnt == 5'd2);
   assign c4_in    = ~first & c4_q;
   assign s4       = pc_bit ^ four_bit ^ c4_in;
   assign ct_in    = ~first & ct_q;
   assign st       = pc_bit ^ i_imm_bit ^ ct_in;

   assign o_link_bit = s4;
   assign o_ibus_adr = pc;
   assign jump       = ctrl.is_jal | (ctrl.is_branch & i_take_branch);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc   <= RESET_PC;
         c4_q <= 1'b0;
         ct_q <= 1'b0;
      end else begin
         if (i_run) begin
            c4_q <= (pc_bit & four_bit) | (pc_bit & c4_in) | (four_bit & c4_in);
            ct_q <= (pc_bit & i_imm_bit) | (pc_bit & ct_in) | (i_imm_bit & ct_in);
         end
         // Bit 31 arrives in the same cycle as the load
         if (i_cnt_done)
            pc <= jump ? {st, tgt_q} : {s4, pc4_q};
      end
   end

   always_ff @(posedge clk) begin
      if (i_run) begin
         pc4_q <= {s4, pc4_q[30:1]};
         tgt_q <= {st, tgt_q[30:1]};
      end
   end

endmodule

`default_nettype wire

//--- hdl/bit_regfile.sv
`default_nettype none

module bit_regfile
   import serv_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   bit_ctrl_if.exe       ctrl,
   input  wire           i_run,
   input  wire bit_cnt_t i_cnt,
   input  wire           i_alu_bit,
   input  wire           i_imm_bit,
   input  wire           i_link_bit,
   output logic          o_rs1_bit,
   output logic          o_rs2_bit
);

   word_t regs [32];
   logic  rd_bit;
   logic  wen;

   always_comb begin
      case (ctrl.rd_src)
         RD_IMM:  rd_bit = i_imm_bit;
         RD_LINK: rd_bit = i_link_bit;
         default: rd_bit = i_alu_bit;
      endcase
   end

   // x0 is never written
   assign wen = i_run & ctrl.rd_en & (ctrl.rd_addr != '0);

   // Cleared at reset so x0 reads zero from the start
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         regs <= '{default: '0};
      else if (wen)
         regs[ctrl.rd_addr][i_cnt] <= rd_bit;
   end

   assign o_rs1_bit = regs[ctrl.rs1_addr][i_cnt];
   assign o_rs2_bit = regs[ctrl.rs2_addr][i_cnt];

endmodule

`default_nettype wire

//--- hdl/bit_state.sv
`default_nettype none

module bit_state
   import serv_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire           i_ibus_ack,
   input  wire           i_dbus_ack,
   input  wire           i_is_store,
   output logic          o_ibus_cyc,
   output logic          o_dbus_cyc,
   output logic          o_run,
   output bit_cnt_t      o_cnt,
   output logic          o_cnt_done
);

   phase_e phase;

   assign o_run      = (phase == PH_RUN);
   assign o_cnt_done = o_run & (o_cnt == 5'd31);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase      <= PH_FETCH;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
         o_cnt      <= '0;
      end else begin
         // Wraps back to zero after bit 31
         if (o_run)
            o_cnt <= o_cnt + 5'd1;
         case (phase)
            PH_FETCH: begin
               if (o_ibus_cyc && i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  phase      <= PH_RUN;
               end else begin
                  o_ibus_cyc <= 1'b1;
               end
            end
            PH_RUN: begin
               if (o_cnt_done && i_is_store) begin
                  o_dbus_cyc <= 1'b1;
                  phase      <= PH_STORE;
               end else if (o_cnt_done) begin
                  o_ibus_cyc <= 1'b1;
                  phase      <= PH_FETCH;
               end
            end
            PH_STORE: begin
               if (i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  o_ibus_cyc <= 1'b1;
                  phase      <= PH_FETCH;
               end
            end
            default: phase <= PH_FETCH;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/serv_pkg.sv
`default_nettype none

package serv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  bit_cnt_t;

   typedef enum logic [1:0] {
      PH_FETCH,
      PH_RUN,
      PH_STORE
   } phase_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   // Where the destination bit comes from
   typedef enum logic [1:0] {
      RD_ALU,
      RD_IMM,
      RD_LINK
   } rd_src_e;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- tb.f
hdl/serv_pkg.sv
hdl/bit_ctrl_if.sv
hdl/bit_state.sv
hdl/bit_decode.sv
hdl/bit_alu.sv
hdl/bit_regfile.sv
hdl/bit_pc_ctrl.sv
hdl/bit_mem_if.sv
hdl/bit_core_top.sv
dv/tb_clkgen.sv
dv/core_checker.sv
dv/tb_top.sv
